//--- lcd_pkg.sv
package lcd_pkg;

	localparam int LCD_POWERUP_CYCLES = 500; // wait before the first command
	localparam int LCD_CMD_PULSE = 10; // e high time per init command
	localparam int LCD_WAIT_FSET = 50;
	localparam int LCD_WAIT_DISP = 50;
	localparam int LCD_WAIT_CLEAR = 200; // clear needs the longest gap
	localparam int LCD_WAIT_ENTRY = 100;

	// start of each init step inside the init count
	localparam int LCD_INIT_DISP_AT = LCD_CMD_PULSE + LCD_WAIT_FSET;
	localparam int LCD_INIT_CLEAR_AT = LCD_INIT_DISP_AT + LCD_CMD_PULSE + LCD_WAIT_DISP;
	localparam int LCD_INIT_ENTRY_AT = LCD_INIT_CLEAR_AT + LCD_CMD_PULSE + LCD_WAIT_CLEAR;
	localparam int LCD_INIT_CYCLES = LCD_INIT_ENTRY_AT + LCD_CMD_PULSE + LCD_WAIT_ENTRY;

	localparam int LCD_WR_CYCLES = 50; // runtime write cycle length
	localparam int LCD_E_RISE = 1; // e high from this count
	localparam int LCD_E_FALL = 13; // through this count
	localparam int LCD_CNT_W = 9; // holds the 500 cycle power-up count

	localparam int LCD_COLS = 16;
	localparam int LCD_COL_W = $clog2(LCD_COLS + 1); // column runs 0..16
	localparam logic [7:0] LCD_LINE0_ADDR = 8'h00;
	localparam logic [7:0] LCD_LINE1_ADDR = 8'h40;

	localparam logic [7:0] LCD_CMD_FSET = 8'h30; // 8-bit interface
	localparam logic [7:0] LCD_CMD_DISP = 8'h08;
	localparam logic [7:0] LCD_CMD_CLEAR = 8'h01;
	localparam logic [7:0] LCD_CMD_ENTRY = 8'h04;
	localparam logic [7:0] LCD_CMD_SET_ADDR = 8'h80;
	localparam logic [7:0] LCD_CHAR_NEWLINE = 8'h0A;

	localparam int LCD_FIFO_DEPTH = 16;
	localparam int LCD_FIFO_AW = $clog2(LCD_FIFO_DEPTH);

	localparam int LCD_WORD_W = 10;
	typedef logic [LCD_WORD_W-1:0] lcd_word_t; // {rs, rw, data[7:0]}

endpackage

//--- lcd_char_fifo.sv
`timescale 1ns/1ps

module lcd_char_fifo import lcd_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       push,
	input  logic [7:0] wdata,
	input  logic       pop,
	output logic [7:0] rdata,
	output logic       full,
	output logic       empty
);

	logic [7:0] mem [LCD_FIFO_DEPTH];
	logic [LCD_FIFO_AW-1:0] wptr;
	logic [LCD_FIFO_AW-1:0] rptr;
	logic [LCD_FIFO_AW:0] count;
	logic do_push;
	logic do_pop;

	assign full = count == (LCD_FIFO_AW + 1)'(LCD_FIFO_DEPTH);
	assign empty = count == '0;
	assign do_push = push && !full; // pushes into a full buffer are dropped
	assign do_pop = pop && !empty;

	always_ff @(posedge clk) begin
		if (rst) begin
			wptr <= '0;
			rptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wptr <= wptr + 1'b1; // wraps at depth
			if (do_pop)
				rptr <= rptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wptr] <= wdata;
		if (do_pop)
			rdata <= mem[rptr]; // valid the cycle after pop, held until the next one
	end

	assert property (@(posedge clk) disable iff (rst) pop |-> !empty);
	// a full buffer has its write pointer back at the read pointer, never past it
	assert property (@(posedge clk) disable iff (rst) full |-> wptr == rptr);

endmodule

//--- lcd_hd44780_ctrl.sv
`timescale 1ns/1ps

module lcd_hd44780_ctrl import lcd_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic [6:0] in_data, // {lines, font, on, cursor, blink, inc, shift}
	input  logic       lcd_enable,
	input  lcd_word_t  lcd_bus,
	output logic       e,
	output logic       rs,
	output logic       rw,
	output logic [7:0] lcd_data,
	output logic       busy
);

	typedef enum logic [1:0] {
		ST_PWR,
		ST_INIT,
		ST_IDLE,
		ST_WR
	} state_t;

	state_t state;
	logic [LCD_CNT_W-1:0] cnt; // shared by all timed states
	lcd_word_t word_q;
	logic [7:0] fset_cmd;
	logic [7:0] disp_cmd;
	logic [7:0] entry_cmd;
	logic [7:0] init_cmd;
	logic init_e;

	assign fset_cmd = LCD_CMD_FSET | {4'b0000, in_data[6:5], 2'b00};
	assign disp_cmd = LCD_CMD_DISP | {5'b00000, in_data[4:2]};
	assign entry_cmd = LCD_CMD_ENTRY | {6'b000000, in_data[1:0]};

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_PWR;
			cnt <= '0;
		end else begin
			case (state)
				ST_PWR: begin
					if (cnt == LCD_CNT_W'(LCD_POWERUP_CYCLES - 1)) begin
						state <= ST_INIT;
						cnt <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				ST_INIT: begin
					if (cnt == LCD_CNT_W'(LCD_INIT_CYCLES - 1)) begin
						state <= ST_IDLE; // init done, accept writes
						cnt <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				ST_IDLE: begin
					if (lcd_enable) begin
						state <= ST_WR;
						cnt <= '0;
					end
				end
				default: begin
					if (cnt == LCD_CNT_W'(LCD_WR_CYCLES)) begin
						state <= ST_IDLE;
						cnt <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && lcd_enable)
			word_q <= lcd_bus; // held for the whole write cycle
	end

	// each command word stays on the bus through its following gap
	always_comb begin
		if (cnt < LCD_CNT_W'(LCD_INIT_DISP_AT)) begin
			init_cmd = fset_cmd;
			init_e = cnt < LCD_CNT_W'(LCD_CMD_PULSE);
		end else if (cnt < LCD_CNT_W'(LCD_INIT_CLEAR_AT)) begin
			init_cmd = disp_cmd;
			init_e = cnt < LCD_CNT_W'(LCD_INIT_DISP_AT + LCD_CMD_PULSE);
		end else if (cnt < LCD_CNT_W'(LCD_INIT_ENTRY_AT)) begin
			init_cmd = LCD_CMD_CLEAR;
			init_e = cnt < LCD_CNT_W'(LCD_INIT_CLEAR_AT + LCD_CMD_PULSE);
		end else begin
			init_cmd = entry_cmd;
			init_e = cnt < LCD_CNT_W'(LCD_INIT_ENTRY_AT + LCD_CMD_PULSE);
		end
	end

	always_comb begin
		e = 1'b0;
		rs = 1'b0;
		rw = 1'b0;
		lcd_data = 8'h00;
		busy = 1'b1; // high in every state but idle
		case (state)
			ST_INIT: begin
				e = init_e;
				lcd_data = init_cmd;
			end
			ST_IDLE: busy = 1'b0;
			ST_WR: begin
				e = (cnt >= LCD_CNT_W'(LCD_E_RISE)) && (cnt <= LCD_CNT_W'(LCD_E_FALL));
				rs = word_q[9];
				rw = word_q[8]; // passed through as given
				lcd_data = word_q[7:0];
			end
			default: ;
		endcase
	end

	// busy only falls at the very end of init or of a write cycle
	assert property (@(posedge clk) disable iff (rst)
		$fell(busy) |->
			($past(state) == ST_INIT && $past(cnt) == LCD_CNT_W'(LCD_INIT_CYCLES - 1)) ||
			($past(state) == ST_WR && $past(cnt) == LCD_CNT_W'(LCD_WR_CYCLES)));

endmodule

//--- lcd_text_writer.sv
`timescale 1ns/1ps

module lcd_text_writer import lcd_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       fifo_empty,
	output logic       fifo_pop,
	input  logic [7:0] fifo_rdata,
	input  logic       busy,
	output logic       lcd_enable,
	output lcd_word_t  lcd_bus
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FETCH,
		ST_ISSUE
	} state_t;

	state_t state;
	logic line; // 0 for the top line
	logic [LCD_COL_W-1:0] col;
	logic [7:0] char_q; // kept across the address write
	logic is_newline;
	logic line_end;
	logic need_addr;
	logic [7:0] next_addr;

	assign is_newline = char_q == LCD_CHAR_NEWLINE;
	assign line_end = col == LCD_COL_W'(LCD_COLS); // past column 15
	assign need_addr = is_newline || line_end;
	assign next_addr = LCD_CMD_SET_ADDR | (line ? LCD_LINE0_ADDR : LCD_LINE1_ADDR);
	assign fifo_pop = (state == ST_IDLE) && !fifo_empty;

	always_comb begin
		lcd_enable = (state == ST_ISSUE) && !busy;
		if (need_addr)
			lcd_bus = {1'b0, 1'b0, next_addr}; // set-address command
		else
			lcd_bus = {1'b1, 1'b0, char_q}; // data write
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			line <= 1'b0;
			col <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (fifo_pop)
						state <= ST_FETCH;
				end
				ST_FETCH: state <= ST_ISSUE;
				default: begin
					if (lcd_enable) begin
						if (need_addr) begin
							line <= ~line;
							col <= '0;
							if (is_newline)
								state <= ST_IDLE; // newline writes no data
						end else begin
							col <= col + 1'b1;
							state <= ST_IDLE;
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_FETCH)
			char_q <= fifo_rdata;
	end

	// every issued word is taken by the controller
	assert property (@(posedge clk) disable iff (rst) lcd_enable |-> !busy ##1 busy);

endmodule

//--- lcd_top.sv
`timescale 1ns/1ps

module lcd_top import lcd_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic [6:0] display_cfg,
	input  logic [7:0] char_data,
	input  logic       char_strobe,
	output logic       lcd_e,
	output logic       lcd_rs,
	output logic       lcd_rw,
	output logic [7:0] lcd_data,
	output logic       char_full,
	output logic       lcd_busy
);

	logic fifo_pop;
	logic fifo_empty;
	logic [7:0] fifo_rdata;
	logic wr_enable;
	lcd_word_t wr_bus;

	lcd_char_fifo u_fifo (
		.clk   (clk),
		.rst   (rst),
		.push  (char_strobe),
		.wdata (char_data),
		.pop   (fifo_pop),
		.rdata (fifo_rdata),
		.full  (char_full),
		.empty (fifo_empty)
	);

	lcd_text_writer u_writer (
		.clk        (clk),
		.rst        (rst),
		.fifo_empty (fifo_empty),
		.fifo_pop   (fifo_pop),
		.fifo_rdata (fifo_rdata),
		.busy       (lcd_busy),
		.lcd_enable (wr_enable),
		.lcd_bus    (wr_bus)
	);

	lcd_hd44780_ctrl u_ctrl (
		.clk        (clk),
		.rst        (rst),
		.in_data    (display_cfg),
		.lcd_enable (wr_enable),
		.lcd_bus    (wr_bus),
		.e          (lcd_e),
		.rs         (lcd_rs),
		.rw         (lcd_rw),
		.lcd_data   (lcd_data),
		.busy       (lcd_busy)
	);

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk,
	output logic rst
);

	localparam int HALF_PERIOD = 50; // 100 ns period
	localparam int RST_CYCLES = 8;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

//--- tb_lcd_top.sv
`timescale 1ns/1ps

module tb_lcd_top;

	localparam int BUSY_AT_START = 500 + 4 * 10 + 50 + 50 + 200 + 100; // power-up plus init
	localparam int N_CHARS = 40;
	localparam int FULL_LIMIT = 500;
	localparam int DRAIN_LIMIT = 20000;

	logic clk;
	logic rst;
	logic [6:0] display_cfg;
	logic [7:0] char_data;
	logic char_strobe;
	logic lcd_e;
	logic lcd_rs;
	logic lcd_rw;
	logic [7:0] lcd_data;
	logic char_full;
	logic lcd_busy;

	logic [7:0] text [N_CHARS];
	logic [8:0] exp_q [$]; // {rs, data}
	logic [9:0] obs_q [$]; // {rs, rw, data} at each e rise
	int len_q [$];
	int errors = 0;
	int checked = 0;
	int widths_checked = 0;
	int pulse_len = 0;
	int width;
	logic prev_e = 1'b0;
	logic full_seen = 1'b0;
	logic timed_out = 1'b0;
	logic [9:0] got;
	logic [8:0] want;

	tb_clk_gen u_clk (.clk(clk), .rst(rst));

	lcd_top u_dut (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// expected panel words from the config and the text
	function automatic void build_expected(input logic [6:0] cfg);
		logic line;
		int col;
		int i;
		line = 1'b0;
		col = 0;
		exp_q.push_back({1'b0, 3'b001, 1'b1, cfg[6], cfg[5], 2'b00}); // function set, 8-bit bus
		exp_q.push_back({1'b0, 5'b00001, cfg[4], cfg[3], cfg[2]}); // on, cursor, blink
		exp_q.push_back({1'b0, 8'h01}); // clear
		exp_q.push_back({1'b0, 6'b000001, cfg[1], cfg[0]}); // increment, shift
		for (i = 0; i < N_CHARS; i++) begin
			if (text[i] == 8'h0A || col == 16) begin
				exp_q.push_back({1'b0, line ? 8'h80 : 8'hC0}); // start of the other line
				line = ~line;
				col = 0;
			end
			if (text[i] != 8'h0A) begin
				exp_q.push_back({1'b1, text[i]});
				col++;
			end
		end
	endfunction

	task automatic wait_init_done();
		int n;
		n = 0;
		@(posedge clk);
		while (rst && n < 100) begin
			@(posedge clk);
			n++;
		end
		assert (!rst) else begin
			$display("timeout: reset was never released");
			timed_out = 1'b1;
			errors++;
		end
		assert (lcd_busy === 1'b1 && lcd_e === 1'b0) else begin
			$display("lcd_busy was not high or lcd_e was not low right after reset");
			errors++;
		end
		n = 0;
		while (lcd_busy && n < BUSY_AT_START + 100) begin
			@(posedge clk);
			n++;
		end
		assert (n < BUSY_AT_START + 100) else begin
			$display("timeout: lcd_busy never fell after the init sequence");
			timed_out = 1'b1;
			errors++;
		end
		assert (n == BUSY_AT_START) else begin
			$display("[ERROR] lcd_busy high cycles expected 0x%0h actual 0x%0h",
				BUSY_AT_START, n);
			errors++;
		end
	endtask

	task automatic push_text();
		int i;
		int n;
		for (i = 0; i < N_CHARS && !timed_out; i++) begin
			n = 0;
			while (char_full && n < FULL_LIMIT) begin
				@(posedge clk);
				n++;
			end
			assert (n < FULL_LIMIT) else begin
				$display("timeout: char_full stayed high and the FIFO never drained");
				timed_out = 1'b1;
				errors++;
			end
			if (!timed_out) begin
				char_data <= text[i];
				char_strobe <= 1'b1;
				@(posedge clk);
				char_strobe <= 1'b0; // one idle cycle so char_full is current
				@(posedge clk);
			end
		end
	endtask

	always @(posedge clk) begin
		if (char_full)
			full_seen = 1'b1;
		if (lcd_e && !prev_e) begin
			obs_q.push_back({lcd_rs, lcd_rw, lcd_data});
			pulse_len = 1;
		end else if (lcd_e) begin
			pulse_len++;
		end else if (prev_e) begin
			len_q.push_back(pulse_len); // pulse just ended
		end
		prev_e = lcd_e;
	end

	always @(posedge clk) begin
		if (obs_q.size() > 0) begin
			got = obs_q.pop_front();
			assert (checked < exp_q.size()) else begin
				$display("e pulse %0d has no expected word, the panel got an extra write", checked);
				errors++;
			end
			if (checked < exp_q.size()) begin
				want = exp_q[checked];
				assert (got[9] == want[8]) else begin
					$display("[ERROR] lcd_rs word %0d expected 0x%0h actual 0x%0h",
						checked, want[8], got[9]);
					errors++;
				end
				assert (got[7:0] == want[7:0]) else begin
					$display("[ERROR] lcd_data word %0d expected 0x%02h actual 0x%02h",
						checked, want[7:0], got[7:0]);
					errors++;
				end
				assert (got[8] == 1'b0) else begin
					$display("[ERROR] lcd_rw word %0d expected 0x0 actual 0x%0h", checked, got[8]);
					errors++;
				end
			end
			checked++;
		end
		if (len_q.size() > 0) begin
			width = len_q.pop_front();
			assert (width == ((widths_checked < 4) ? 10 : 13)) else begin // init pulses are shorter
				$display("[ERROR] lcd_e pulse %0d width expected 0x%0h actual 0x%0h",
					widths_checked, (widths_checked < 4) ? 10 : 13, width);
				errors++;
			end
			widths_checked++;
		end
	end

	initial begin
		logic [31:0] rnd;
		logic [7:0] code;
		int i;
		int n;
		rnd = lcg_next(32'd36);
		display_cfg = rnd[22:16];
		char_data = 8'h00;
		char_strobe = 1'b0;
		for (i = 0; i < N_CHARS; i++) begin
			rnd = lcg_next(rnd);
			code = rnd[23:16] % 8'd95;
			if (i == 28 || (i > 20 && rnd[26:24] == 3'd0))
				text[i] = 8'h0A; // newline
			else
				text[i] = 8'h20 + code; // printable ascii
		end
		build_expected(display_cfg);
		wait_init_done();
		if (!timed_out)
			push_text();
		n = 0;
		while (!timed_out && (checked < exp_q.size() || widths_checked < exp_q.size())
			&& n < DRAIN_LIMIT) begin
			@(posedge clk);
			n++;
		end
		assert (n < DRAIN_LIMIT) else begin
			$display("timeout: not all expected panel words appeared on the bus");
			timed_out = 1'b1;
			errors++;
		end
		if (!timed_out)
			repeat (200) @(posedge clk); // room for a stray extra word
		assert (full_seen) else begin
			$display("char_full never went high during the push burst");
			errors++;
		end
		assert (checked == exp_q.size()) else begin
			$display("[ERROR] word count expected 0x%0h actual 0x%0h", exp_q.size(), checked);
			errors++;
		end
		$display("words checked %0d, errors %0d", checked, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- list.f
lcd_pkg.sv
lcd_char_fifo.sv
lcd_hd44780_ctrl.sv
lcd_text_writer.sv
lcd_top.sv
tb_clk_gen.sv
tb_lcd_top.sv

//--- Makefile
TOP = tb_lcd_top

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee run.log
	grep -q "TEST PASSED" run.log

lint:
	verilator --lint-only --timing -Wall -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir run.log

.PHONY: all build run lint clean
